// File: Bender.yml
package:
  name: rsa

sources:
  # packages come before the modules that import them
  - files:
      - hdl/rsa_data_pkg.sv
      - hdl/rsa_ctrl_pkg.sv
      - hdl/rsa_feeder.sv
      - hdl/rsa_pe.sv
      - hdl/rsa_pe_array.sv
      - hdl/rsa_drain.sv
      - hdl/rsa_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_rsa.sv

// File: hdl/rsa_ctrl_pkg.sv
package rsa_ctrl_pkg;

    // wavefront bits travelling with each term through the grid
    typedef struct packed {
        logic cal_en;     // multiply this cycle
        logic cal_first;  // start a new sum
        logic cal_done;   // this was the final term
    } wave_t;

    // operand port handshake
    typedef enum logic [1:0] {
        feed_idle,
        feed_wait_buffer,   // first beat held until the drain is free
        feed_capture,       // beat enters the array
        feed_wait_release
    } feed_state_e;

    // result port handshake
    typedef enum logic [1:0] {
        drain_collect,
        drain_offer,
        drain_wait_release
    } drain_state_e;

endpackage

// File: hdl/rsa_data_pkg.sv
package rsa_data_pkg;

    // array shape
    localparam int ROWS = 4;
    localparam int COLS = 4;

    // one operand or result element
    typedef logic [15:0] elem_t;  // sums wrap at 16 bits

    // one column of A
    typedef elem_t [ROWS-1:0] a_vec_t;  // element r goes to row r

    // one row of B
    typedef elem_t [COLS-1:0] b_vec_t;  // element c goes to column c

    // one column of C as it leaves the array
    typedef elem_t [ROWS-1:0] c_vec_t;

    // operand beat on the host side
    typedef struct packed {
        a_vec_t a_vec;  // A[*][k]
        b_vec_t b_vec;  // B[k][*]
        logic   last;   // final term of the job
    } operand_beat_t;

    // result beat on the host side
    typedef struct packed {
        c_vec_t c_vec;  // C[*][c]
        logic   last;   // set on column COLS-1
    } result_beat_t;

endpackage

// File: hdl/rsa_drain.sv
`timescale 1ns/1ns

module rsa_drain
    import rsa_data_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic [ROWS-1:0] i_row_val,
    input  c_vec_t          i_row_res,
    output logic            o_buf_empty,
    output logic            o_res_req,
    output result_beat_t    o_res_beat,
    input  logic            i_res_ack
);

    typedef logic [$clog2(COLS):0]   col_cnt_t;  // 0 up to COLS
    typedef logic [$clog2(COLS)-1:0] col_idx_t;

    drain_state_e    state_q;
    col_cnt_t        cnt_q [ROWS];    // elements received per row
    col_idx_t        col_q;           // column on offer
    elem_t           buf_q [ROWS][COLS];
    logic [ROWS-1:0] wr_en;
    logic            all_full;
    logic            any_held;
    logic            last_col;

    always_comb begin
        all_full = 1'b1;
        any_held = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            wr_en[r] = i_row_val[r] && (state_q == drain_collect) && (cnt_q[r] != COLS);
            if (cnt_q[r] != COLS) begin
                all_full = 1'b0;
            end
            if (cnt_q[r] != '0) begin
                any_held = 1'b1;
            end
        end
    end

    assign last_col = (col_q == col_idx_t'(COLS - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= drain_collect;
            col_q   <= '0;
            for (int r = 0; r < ROWS; r++) begin
                cnt_q[r] <= '0;
            end
        end else begin
            for (int r = 0; r < ROWS; r++) begin
                if (wr_en[r]) begin
                    cnt_q[r] <= cnt_q[r] + 1'b1;
                end
            end
            case (state_q)
                drain_collect: begin
                    if (all_full) begin
                        state_q <= drain_offer;
                    end
                end
                drain_offer: begin
                    if (i_res_ack) begin
                        state_q <= drain_wait_release;
                    end
                end
                drain_wait_release: begin
                    if (!i_res_ack) begin
                        if (last_col) begin
                            state_q <= drain_collect;  // buffer free for the next job
                            col_q   <= '0;
                            for (int r = 0; r < ROWS; r++) begin
                                cnt_q[r] <= '0;
                            end
                        end else begin
                            state_q <= drain_offer;
                            col_q   <= col_q + 1'b1;
                        end
                    end
                end
                default: state_q <= drain_collect;
            endcase
        end
    end

    // element c of each row arrives in column order
    always_ff @(posedge clk) begin
        for (int r = 0; r < ROWS; r++) begin
            if (wr_en[r]) begin
                buf_q[r][col_idx_t'(cnt_q[r])] <= i_row_res[r];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            o_res_beat.c_vec[r] = buf_q[r][col_q];
        end
        o_res_beat.last = last_col;
    end

    assign o_res_req   = (state_q == drain_offer);
    assign o_buf_empty = (state_q == drain_collect) && !any_held;

endmodule

// File: hdl/rsa_feeder.sv
`timescale 1ns/1ns

module rsa_feeder
    import rsa_data_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_op_req,
    input  operand_beat_t i_op_beat,
    output logic          o_op_ack,
    input  logic          i_buf_empty,
    output a_vec_t        o_west,
    output b_vec_t        o_south,
    output wave_t         o_wave
);

    feed_state_e   state_q;
    operand_beat_t beat_q;       // beat presented during the capture cycle
    logic          job_start_q;  // next beat opens a new job
    logic          pending_q;    // last beat sent, results not yet seen in the drain
    logic          stall;
    logic          load;
    logic          cap;

    // a new job waits until the previous one has fully left the drain
    assign stall = job_start_q && (pending_q || !i_buf_empty);

    assign load = !stall &&
                  (((state_q == feed_idle) && i_op_req) || (state_q == feed_wait_buffer));

    assign cap = (state_q == feed_capture);

    assign o_op_ack = (state_q == feed_capture) || (state_q == feed_wait_release);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q     <= feed_idle;
            job_start_q <= 1'b1;
            pending_q   <= 1'b0;
        end else begin
            case (state_q)
                feed_idle: begin
                    if (load) begin
                        state_q <= feed_capture;
                    end else if (i_op_req) begin
                        state_q <= feed_wait_buffer;
                    end
                end
                feed_wait_buffer: begin
                    if (load) begin
                        state_q <= feed_capture;
                    end
                end
                feed_capture: begin
                    state_q     <= feed_wait_release;
                    job_start_q <= beat_q.last;  // after the last beat a new job begins
                end
                feed_wait_release: begin
                    if (!i_op_req) begin
                        state_q <= feed_idle;
                    end
                end
                default: state_q <= feed_idle;
            endcase

            if (cap && beat_q.last) begin
                pending_q <= 1'b1;
            end else if (!i_buf_empty) begin
                pending_q <= 1'b0;  // results of that job have started to arrive
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            beat_q <= i_op_beat;
        end
    end

    // wave enters cell (0,0) together with row 0 and column 0 operands
    assign o_wave = '{cal_en:    cap,
                      cal_first: cap && job_start_q,
                      cal_done:  cap && beat_q.last};

    // row r of A is held back r cycles
    for (genvar r = 0; r < ROWS; r++) begin : g_a_skew
        if (r == 0) begin : g_direct
            assign o_west[r] = beat_q.a_vec[r];
        end else begin : g_delay
            elem_t dly_q [r];

            always_ff @(posedge clk) begin
                dly_q[0] <= beat_q.a_vec[r];
                for (int j = 1; j < r; j++) begin
                    dly_q[j] <= dly_q[j-1];
                end
            end

            assign o_west[r] = dly_q[r-1];
        end
    end

    // column c of B is held back c cycles
    for (genvar c = 0; c < COLS; c++) begin : g_b_skew
        if (c == 0) begin : g_direct
            assign o_south[c] = beat_q.b_vec[c];
        end else begin : g_delay
            elem_t dly_q [c];

            always_ff @(posedge clk) begin
                dly_q[0] <= beat_q.b_vec[c];
                for (int j = 1; j < c; j++) begin
                    dly_q[j] <= dly_q[j-1];
                end
            end

            assign o_south[c] = dly_q[c-1];
        end
    end

endmodule

// File: hdl/rsa_pe.sv
`timescale 1ns/1ns

module rsa_pe
    import rsa_data_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst_n,
    input  wave_t i_wave,
    input  elem_t i_west,
    input  elem_t i_south,
    input  logic  i_res_val,
    input  elem_t i_res,
    output wave_t o_wave,
    output elem_t o_east,
    output elem_t o_north,
    output logic  o_res_val,
    output elem_t o_res
);

    elem_t acc_q;
    elem_t prod;
    elem_t sum;

    assign prod = i_west * i_south;                             // low 16 bits kept
    assign sum  = (i_wave.cal_first ? elem_t'(0) : acc_q) + prod;

    // control path, wave moves one hop per cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wave    <= '0;
            o_res_val <= 1'b0;
        end else begin
            o_wave <= i_wave;
            if (i_wave.cal_done) begin
                o_res_val <= 1'b1;
            end else begin
                o_res_val <= i_res_val;  // shift toward the west edge
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        o_east  <= i_west;
        o_north <= i_south;
        if (i_wave.cal_en) begin
            acc_q <= sum;
        end
        if (i_wave.cal_done) begin
            o_res <= sum;    // finished sum including this term
        end else begin
            o_res <= i_res;
        end
    end

endmodule

// File: hdl/rsa_pe_array.sv
`timescale 1ns/1ns

module rsa_pe_array
    import rsa_data_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst_n,
    input  a_vec_t          i_west,
    input  b_vec_t          i_south,
    input  wave_t           i_wave,
    output logic [ROWS-1:0] o_row_val,
    output c_vec_t          o_row_res
);

    wave_t cell_wave    [ROWS][COLS];
    elem_t cell_east    [ROWS][COLS];
    elem_t cell_north   [ROWS][COLS];
    logic  cell_res_val [ROWS][COLS];
    elem_t cell_res     [ROWS][COLS];

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            wave_t w_in;
            elem_t a_in;
            elem_t b_in;
            logic  rv_in;
            elem_t r_in;

            if (r == 0 && c == 0) begin : g_wave_src
                assign w_in = i_wave;
            end else if (r == 0) begin : g_wave_east
                assign w_in = cell_wave[0][c-1];   // row 0 carries it east
            end else begin : g_wave_north
                assign w_in = cell_wave[r-1][c];   // then up each column
            end

            if (c == 0) begin : g_a_edge
                assign a_in = i_west[r];
            end else begin : g_a_link
                assign a_in = cell_east[r][c-1];
            end

            if (r == 0) begin : g_b_edge
                assign b_in = i_south[c];
            end else begin : g_b_link
                assign b_in = cell_north[r-1][c];
            end

            if (c == COLS - 1) begin : g_res_edge
                assign rv_in = 1'b0;  // nothing east of the last column
                assign r_in  = '0;
            end else begin : g_res_link
                assign rv_in = cell_res_val[r][c+1];
                assign r_in  = cell_res[r][c+1];
            end

            rsa_pe u_pe (
                .clk       (clk),
                .i_rst_n   (i_rst_n),
                .i_wave    (w_in),
                .i_west    (a_in),
                .i_south   (b_in),
                .i_res_val (rv_in),
                .i_res     (r_in),
                .o_wave    (cell_wave[r][c]),
                .o_east    (cell_east[r][c]),
                .o_north   (cell_north[r][c]),
                .o_res_val (cell_res_val[r][c]),
                .o_res     (cell_res[r][c])
            );
        end

        assign o_row_val[r] = cell_res_val[r][0];
        assign o_row_res[r] = cell_res[r][0];
    end

endmodule

// File: hdl/rsa_top.sv
`timescale 1ns/1ns

module rsa_top
    import rsa_data_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_op_req,
    input  operand_beat_t i_op_beat,
    output logic          o_op_ack,
    output logic          o_res_req,
    output result_beat_t  o_res_beat,
    input  logic          i_res_ack
);

    a_vec_t          west;       // skewed A into column 0
    b_vec_t          south;      // skewed B into row 0
    wave_t           wave;       // wavefront into cell (0,0)
    logic [ROWS-1:0] row_val;
    c_vec_t          row_res;
    logic            buf_empty;

    rsa_feeder u_feeder (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_op_req    (i_op_req),
        .i_op_beat   (i_op_beat),
        .o_op_ack    (o_op_ack),
        .i_buf_empty (buf_empty),
        .o_west      (west),
        .o_south     (south),
        .o_wave      (wave)
    );

    rsa_pe_array u_pe_array (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_west    (west),
        .i_south   (south),
        .i_wave    (wave),
        .o_row_val (row_val),
        .o_row_res (row_res)
    );

    rsa_drain u_drain (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_row_val   (row_val),
        .i_row_res   (row_res),
        .o_buf_empty (buf_empty),
        .o_res_req   (o_res_req),
        .o_res_beat  (o_res_beat),
        .i_res_ack   (i_res_ack)
    );

endmodule

// File: include/tb_rsa_ref.svh
`ifndef TB_RSA_REF_SVH
`define TB_RSA_REF_SVH

// column c of C = A * B for job j, every product and sum kept to 16 bits
function automatic c_vec_t ref_column(input int j, input int c);
    c_vec_t      col;
    logic [31:0] prod;
    for (int r = 0; r < ROWS; r++) begin
        col[r] = '0;
        for (int k = 0; k < job_k[j]; k++) begin
            prod   = mat_a[j][r][k] * mat_b[j][k][c];
            col[r] = col[r] + prod[15:0];  // wraps like the array
        end
    end
    return col;
endfunction

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
endtask

// A is the identity, B a pattern built from row and column
task automatic fill_identity(input int j, input string name);
    job_k[j]    = ROWS;
    job_name[j] = name;
    job_slow[j] = 1'b0;
    for (int k = 0; k < ROWS; k++) begin
        for (int r = 0; r < ROWS; r++) begin
            mat_a[j][r][k] = (r == k) ? elem_t'(1) : elem_t'(0);
        end
        for (int c = 0; c < COLS; c++) begin
            mat_b[j][k][c] = elem_t'(16'ha000 | (k << 4) | c);
        end
    end
endtask

task automatic fill_random(input int j, input int k_len, input string name,
                           input bit slow);
    job_k[j]    = k_len;
    job_name[j] = name;
    job_slow[j] = slow;
    for (int k = 0; k < k_len; k++) begin
        for (int r = 0; r < ROWS; r++) begin
            mat_a[j][r][k] = elem_t'($urandom);
        end
        for (int c = 0; c < COLS; c++) begin
            mat_b[j][k][c] = elem_t'($urandom);
        end
    end
endtask

`endif

// File: testbench/tb_rsa.sv
`timescale 1ns/1ns

module tb_rsa
    import rsa_data_pkg::*;
();

    localparam int NJOBS      = 10;
    localparam int KMAX       = 20;
    localparam int BEAT_BOUND = 50;   // cycles allowed for any one beat
    localparam int SETUP      = 200;  // reset, idle check and pipeline fill

    logic          clk;
    logic          i_rst_n;
    logic          i_op_req;
    operand_beat_t i_op_beat;
    logic          o_op_ack;
    logic          o_res_req;
    result_beat_t  o_res_beat;
    logic          i_res_ack;

    elem_t mat_a    [NJOBS][ROWS][KMAX];
    elem_t mat_b    [NJOBS][KMAX][COLS];
    int    job_k    [NJOBS];
    string job_name [NJOBS];
    bit    job_slow [NJOBS];  // checker stretches its acks

    int errors;
    int checks;
    int limit_cycles;

    `include "tb_rsa_ref.svh"

    rsa_top u_rsa_top (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_op_req   (i_op_req),
        .i_op_beat  (i_op_beat),
        .o_op_ack   (o_op_ack),
        .o_res_req  (o_res_req),
        .o_res_beat (o_res_beat),
        .i_res_ack  (i_res_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // host side of the operand port, one four-phase handshake per beat
    task automatic send_job(input int j);
        operand_beat_t beat;
        for (int k = 0; k < job_k[j]; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                beat.a_vec[r] = mat_a[j][r][k];
            end
            for (int c = 0; c < COLS; c++) begin
                beat.b_vec[c] = mat_b[j][k][c];
            end
            beat.last = (k == job_k[j] - 1);
            @(negedge clk);
            i_op_beat = beat;
            i_op_req  = 1'b1;
            do @(negedge clk); while (!o_op_ack);
            i_op_req = 1'b0;
            do @(negedge clk); while (o_op_ack);
        end
    endtask

    // host side of the result port, COLS beats per job
    task automatic receive_job(input int j);
        c_vec_t expected;
        int     delay;
        for (int c = 0; c < COLS; c++) begin
            do @(negedge clk); while (!o_res_req);
            expected = ref_column(j, c);
            check_value($sformatf("%s col %0d", job_name[j], c), expected, o_res_beat.c_vec);
            if (o_res_beat.last !== (c == COLS - 1)) begin
                errors++;
                $display("%s: last flag is %b on result beat %0d of %0d", job_name[j],
                         o_res_beat.last, c, COLS);
            end
            delay = job_slow[j] ? int'($urandom % 8) : 0;
            repeat (delay) @(negedge clk);
            i_res_ack = 1'b1;
            do @(negedge clk); while (o_res_req);
            delay = job_slow[j] ? int'($urandom % 4) : 0;
            repeat (delay) @(negedge clk);
            i_res_ack = 1'b0;
        end
    endtask

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: handshakes did not finish within %0d cycles", limit_cycles);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("test failed");
        $finish;
    end

    initial begin
        int seed;
        int total_beats;
        bit extra;
        i_rst_n   = 1'b0;
        i_op_req  = 1'b0;
        i_op_beat = '0;
        i_res_ack = 1'b0;
        errors    = 0;
        checks    = 0;
        extra     = 1'b0;
        seed      = 32'h8fe6;
        void'($urandom(seed));

        fill_identity(0, "identity");
        fill_random(1, 4, "random_k4", 1'b0);
        fill_random(2, 1, "depth_k1", 1'b0);
        fill_random(3, KMAX, "depth_k20", 1'b0);
        for (int j = 4; j < NJOBS; j++) begin
            fill_random(j, 1 + int'($urandom % 8), $sformatf("back_to_back_%0d", j), 1'b1);
        end

        total_beats = NJOBS * COLS;  // result beats
        for (int j = 0; j < NJOBS; j++) begin
            total_beats += job_k[j];
        end
        limit_cycles = SETUP + total_beats * BEAT_BOUND;

        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        // nothing may move without a request
        repeat (8) begin
            @(negedge clk);
            check_value("idle_op_ack", 64'd0, 64'(o_op_ack));
            check_value("idle_res_req", 64'd0, 64'(o_res_req));
        end

        fork
            begin
                for (int j = 0; j < NJOBS; j++) begin
                    send_job(j);
                end
            end
            begin
                for (int j = 0; j < NJOBS; j++) begin
                    receive_job(j);
                end
            end
        join

        repeat (40) begin
            @(negedge clk);
            if (o_res_req) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            errors++;
            $display("result port offered a beat after the last expected one");
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
hdl/rsa_data_pkg.sv
hdl/rsa_ctrl_pkg.sv
hdl/rsa_feeder.sv
hdl/rsa_pe.sv
hdl/rsa_pe_array.sv
hdl/rsa_drain.sv
hdl/rsa_top.sv
testbench/tb_rsa.sv
